// ==== sim.f ====
+incdir+include
source/riscv_pkg.sv
source/riscv_fstage.sv
source/riscv_regfile.sv
source/riscv_dstage.sv
source/riscv_alu.sv
source/riscv_bcu.sv
source/riscv_estage.sv
source/riscv_wbstage.sv
source/riscv_datapath.sv
dv/riscv_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module riscv_datapath_tb -o riscv_datapath_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/riscv_datapath_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0

// ==== include/riscv_tb_table.svh ====
`ifndef RISCV_TB_TABLE_SVH
`define RISCV_TB_TABLE_SVH

// program rows: instruction word, control word (one row per word, pc = row * 4)
// expected rows: rd, data in write-back order
task automatic load_tables();
  ////////////////////
  // operands and alu
  push_inst(i_type(5, 0, 0, 1, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(i_type(-3, 0, 0, 2, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(i_type(40, 0, 0, 3, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(r_type(0, 2, 1, 0, 4), alu_ctrl(riscv_pkg::ALU_ADD, 1'b0));
  push_inst(r_type(32, 2, 1, 0, 5), alu_ctrl(riscv_pkg::ALU_SUB, 1'b0));
  push_inst(r_type(0, 2, 1, 7, 6), alu_ctrl(riscv_pkg::ALU_AND, 1'b0));
  push_inst(r_type(0, 2, 1, 6, 7), alu_ctrl(riscv_pkg::ALU_OR, 1'b0));
  push_inst(r_type(0, 2, 1, 4, 8), alu_ctrl(riscv_pkg::ALU_XOR, 1'b0));
  push_inst(r_type(0, 1, 2, 2, 9), alu_ctrl(riscv_pkg::ALU_SLT, 1'b0));
  push_inst(r_type(0, 1, 2, 3, 10), alu_ctrl(riscv_pkg::ALU_SLTU, 1'b0));
  push_inst(r_type(0, 3, 1, 1, 11), alu_ctrl(riscv_pkg::ALU_SLL, 1'b0));
  push_inst(r_type(0, 3, 2, 5, 12), alu_ctrl(riscv_pkg::ALU_SRL, 1'b0));
  push_inst(r_type(32, 3, 2, 5, 13), alu_ctrl(riscv_pkg::ALU_SRA, 1'b0));
  push_inst(u_type(32'h80000, 14), lui_ctrl());
  push_inst(i_type(7, 1, 0, 0, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));  // x0
  push_inst(i_type(9, 0, 0, 15, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(r_type(0, 0, 0, 0, 16), alu_ctrl(riscv_pkg::ALU_ADD, 1'b0));
  ////////////////////
  // taken branches, each skips two markers
  push_inst(b_type(12, 1, 1, 0), branch_ctrl(riscv_pkg::BR_EQ));
  push_marker(1);
  push_marker(2);
  push_inst(b_type(12, 2, 1, 1), branch_ctrl(riscv_pkg::BR_NE));
  push_marker(3);
  push_marker(4);
  push_inst(b_type(12, 1, 2, 4), branch_ctrl(riscv_pkg::BR_LT));
  push_marker(5);
  push_marker(6);
  push_inst(b_type(12, 2, 1, 5), branch_ctrl(riscv_pkg::BR_GE));
  push_marker(7);
  push_marker(8);
  push_inst(b_type(12, 2, 1, 6), branch_ctrl(riscv_pkg::BR_LTU));
  push_marker(9);
  push_marker(10);
  push_inst(b_type(12, 1, 2, 7), branch_ctrl(riscv_pkg::BR_GEU));
  push_marker(11);
  push_marker(12);
  // not taken
  push_inst(b_type(12, 2, 1, 0), branch_ctrl(riscv_pkg::BR_EQ));
  push_inst(i_type(17, 0, 0, 17, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(b_type(12, 1, 2, 6), branch_ctrl(riscv_pkg::BR_LTU));
  ////////////////////
  // jumps
  push_inst(j_type(12, 20), jump_ctrl(1'b0));  // pc 152
  push_marker(13);
  push_marker(14);
  push_inst(i_type(184, 0, 0, 21, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  push_inst(r_type(0, 5, 4, 0, 24), alu_ctrl(riscv_pkg::ALU_ADD, 1'b0));
  push_inst(i_type(1, 21, 0, 23, OP_JALR), jump_ctrl(1'b1));  // 185 -> 184
  push_marker(15);
  push_marker(16);
  push_inst(r_type(32, 1, 0, 0, 25), alu_ctrl(riscv_pkg::ALU_SUB, 1'b0));

  ////////////////////
  // expected write-backs
  expect_wb(1, 64'h0000_0000_0000_0005);
  expect_wb(2, 64'hFFFF_FFFF_FFFF_FFFD);
  expect_wb(3, 64'h0000_0000_0000_0028);
  expect_wb(4, 64'h0000_0000_0000_0002);
  expect_wb(5, 64'h0000_0000_0000_0008);
  expect_wb(6, 64'h0000_0000_0000_0005);
  expect_wb(7, 64'hFFFF_FFFF_FFFF_FFFD);
  expect_wb(8, 64'hFFFF_FFFF_FFFF_FFF8);
  expect_wb(9, 64'h0000_0000_0000_0001);
  expect_wb(10, 64'h0000_0000_0000_0000);
  expect_wb(11, 64'h0000_0500_0000_0000);
  expect_wb(12, 64'h0000_0000_00FF_FFFF);
  expect_wb(13, 64'hFFFF_FFFF_FFFF_FFFF);
  expect_wb(14, 64'hFFFF_FFFF_8000_0000);
  expect_wb(15, 64'h0000_0000_0000_0009);
  expect_wb(16, 64'h0000_0000_0000_0000);
  expect_wb(17, 64'h0000_0000_0000_0011);
  expect_wb(20, 64'h0000_0000_0000_009C);  // jal link
  expect_wb(21, 64'h0000_0000_0000_00B8);
  expect_wb(24, 64'h0000_0000_0000_000A);
  expect_wb(23, 64'h0000_0000_0000_00B0);  // jalr link
  expect_wb(25, 64'hFFFF_FFFF_FFFF_FFFB);
endtask

`endif

// ==== dv/riscv_datapath_tb.sv ====
module riscv_datapath_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 20;
  localparam int OP_IMM       = 32'h13;
  localparam int OP_JALR      = 32'h67;
  localparam riscv_pkg::inst_t NOP = 32'h0000_0013;

  logic                   clk;
  logic                   rst;
  logic                   stall;
  riscv_pkg::inst_t       inst;
  riscv_pkg::riscv_ctrl_t ctrl;
  riscv_pkg::xlen_t       pc;
  riscv_pkg::riscv_wb_t   wb;

  riscv_pkg::inst_t       prog_inst [$];
  riscv_pkg::riscv_ctrl_t prog_ctrl [$];
  riscv_pkg::reg_addr_t   exp_rd [$];
  riscv_pkg::xlen_t       exp_data [$];
  int                     matched;
  integer                 seed;

  riscv_datapath i_riscv_datapath (
    .i_riscv_datapath_clk (clk),
    .i_rst                (rst),
    .i_stall              (stall),
    .i_inst               (inst),
    .i_ctrl               (ctrl),
    .o_pc                 (pc),
    .o_wb                 (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // rv64 encoders

  function automatic riscv_pkg::inst_t r_type(input int f7, input int rs2, input int rs1,
                                              input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic riscv_pkg::inst_t i_type(input int imm, input int rs1, input int f3,
                                              input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic riscv_pkg::inst_t u_type(input int imm, input int rd);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic riscv_pkg::inst_t b_type(input int imm, input int rs2, input int rs1,
                                              input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic riscv_pkg::inst_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  ////////////////////
  // control words from the outside control unit

  function automatic riscv_pkg::riscv_ctrl_t alu_ctrl(input riscv_pkg::alu_op_t op,
                                                      input logic use_imm);
    riscv_pkg::riscv_ctrl_t c;
    c         = '0;
    c.regw    = 1'b1;
    c.bsel    = use_imm;
    c.immsrc  = riscv_pkg::IMM_I;
    c.aluctrl = op;
    return c;
  endfunction

  function automatic riscv_pkg::riscv_ctrl_t lui_ctrl();
    riscv_pkg::riscv_ctrl_t c;
    c           = '0;
    c.regw      = 1'b1;
    c.immsrc    = riscv_pkg::IMM_U;
    c.resultsrc = riscv_pkg::RES_IMM;
    return c;
  endfunction

  function automatic riscv_pkg::riscv_ctrl_t branch_ctrl(input riscv_pkg::bcond_t cond);
    riscv_pkg::riscv_ctrl_t c;
    c         = '0;
    c.asel    = 1'b1;  // target is pc + imm
    c.bsel    = 1'b1;
    c.immsrc  = riscv_pkg::IMM_B;
    c.aluctrl = riscv_pkg::ALU_ADD;
    c.bcond   = cond;
    return c;
  endfunction

  function automatic riscv_pkg::riscv_ctrl_t jump_ctrl(input logic through_reg);
    riscv_pkg::riscv_ctrl_t c;
    c           = '0;
    c.regw      = 1'b1;
    c.jump      = 1'b1;
    c.asel      = !through_reg;
    c.bsel      = 1'b1;
    c.immsrc    = through_reg ? riscv_pkg::IMM_I : riscv_pkg::IMM_J;
    c.aluctrl   = riscv_pkg::ALU_ADD;
    c.resultsrc = riscv_pkg::RES_PC4;
    return c;
  endfunction

  task automatic push_inst(input riscv_pkg::inst_t word, input riscv_pkg::riscv_ctrl_t cw);
    prog_inst.push_back(word);
    prog_ctrl.push_back(cw);
  endtask

  // must never reach writeback
  task automatic push_marker(input int tag);
    push_inst(i_type(tag, 0, 0, 31, OP_IMM), alu_ctrl(riscv_pkg::ALU_ADD, 1'b1));
  endtask

  task automatic expect_wb(input int rd, input riscv_pkg::xlen_t data);
    exp_rd.push_back(rd[4:0]);
    exp_data.push_back(data);
  endtask

  `include "riscv_tb_table.svh"

  task automatic check_value(input string what, input riscv_pkg::xlen_t got,
                             input riscv_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic observe_wb();
    if (wb.valid) begin
      if (matched >= exp_rd.size()) begin
        $display("an extra write-back to x%0d appeared after the expected sequence", wb.rd);
        $display("TESTS FAILED");
        $fatal(1, "extra write-back");
      end
      check_value("wb.rd", riscv_pkg::xlen_t'(wb.rd), riscv_pkg::xlen_t'(exp_rd[matched]));
      check_value("wb.data", wb.data, exp_data[matched]);
      matched++;
    end
  endtask

  // instruction memory returns a word with regw clear past the end
  task automatic feed_inst();
    int idx;
    idx   = int'(pc >> 2);
    stall = (($random(seed) & 3) == 0);
    if (idx < prog_inst.size()) begin
      inst = prog_inst[idx];
      ctrl = prog_ctrl[idx];
    end else begin
      inst = NOP;
      ctrl = '0;
    end
  endtask

  initial begin
    seed    = 32'h217d;
    rst     = 1'b1;
    stall   = 1'b0;
    inst    = NOP;
    ctrl    = '0;
    matched = 0;
    load_tables();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("wb.valid in reset", riscv_pkg::xlen_t'(wb.valid), '0);
    end
    rst = 1'b0;
    check_value("pc after reset", pc, riscv_pkg::RESET_PC);
    feed_inst();
    while (matched < exp_rd.size()) begin
      #1;  // o_wb follows the stall just driven
      observe_wb();
      @(negedge clk);
      feed_inst();
    end
    repeat (DRAIN_CYCLES) begin  // nothing may follow the last entry
      #1;
      observe_wb();
      @(negedge clk);
      feed_inst();
    end
    $display("TESTS PASSED");
    $finish;
  end

  // watchdog
  initial begin
    @(negedge rst);
    repeat (prog_inst.size() * 12) @(posedge clk);
    $display("timeout: the pipeline hung, only %0d of %0d write-backs seen",
             matched, exp_rd.size());
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== source/riscv_datapath.sv ====
module riscv_datapath (
  input  logic                   i_riscv_datapath_clk,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  riscv_pkg::inst_t       i_inst,
  input  riscv_pkg::riscv_ctrl_t i_ctrl,
  output riscv_pkg::xlen_t       o_pc,
  output riscv_pkg::riscv_wb_t   o_wb
);

  ////////////////////
  // decode to execute
  riscv_pkg::xlen_t       pc_d;
  riscv_pkg::xlen_t       pc4_d;
  riscv_pkg::xlen_t       rs1data_d;
  riscv_pkg::xlen_t       rs2data_d;
  riscv_pkg::xlen_t       imm_d;
  riscv_pkg::reg_addr_t   rd_d;
  riscv_pkg::riscv_ctrl_t ctrl_d;
  logic                   valid_d;

  ////////////////////
  // execute to writeback and fetch
  logic                   redirect_e;
  riscv_pkg::xlen_t       alu_result_e;
  riscv_pkg::xlen_t       pc4_e;
  riscv_pkg::xlen_t       imm_e;
  riscv_pkg::reg_addr_t   rd_e;
  logic                   regw_e;
  riscv_pkg::res_src_t    resultsrc_e;
  logic                   valid_e;

  riscv_fstage u_riscv_fstage (
    .i_riscv_fstage_clk (i_riscv_datapath_clk),
    .i_rst              (i_rst),
    .i_stall            (i_stall),
    .i_redirect         (redirect_e),
    .i_target           (alu_result_e),
    .o_pc               (o_pc)
  );

  riscv_dstage u_riscv_dstage (
    .i_riscv_dstage_clk (i_riscv_datapath_clk),
    .i_rst              (i_rst),
    .i_stall            (i_stall),
    .i_flush            (redirect_e),
    .i_pc               (o_pc),
    .i_inst             (i_inst),
    .i_ctrl             (i_ctrl),
    .i_wb               (o_wb),  // register file write port
    .o_pc               (pc_d),
    .o_pc4              (pc4_d),
    .o_rs1data          (rs1data_d),
    .o_rs2data          (rs2data_d),
    .o_imm              (imm_d),
    .o_rd               (rd_d),
    .o_ctrl             (ctrl_d),
    .o_valid            (valid_d)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_estage_clk (i_riscv_datapath_clk),
    .i_rst              (i_rst),
    .i_stall            (i_stall),
    .i_pc               (pc_d),
    .i_pc4              (pc4_d),
    .i_rs1data          (rs1data_d),
    .i_rs2data          (rs2data_d),
    .i_imm              (imm_d),
    .i_rd               (rd_d),
    .i_ctrl             (ctrl_d),
    .i_valid            (valid_d),
    .o_redirect         (redirect_e),
    .o_alu_result       (alu_result_e),
    .o_pc4              (pc4_e),
    .o_imm              (imm_e),
    .o_rd               (rd_e),
    .o_regw             (regw_e),
    .o_resultsrc        (resultsrc_e),
    .o_valid            (valid_e)
  );

  riscv_wbstage u_riscv_wbstage (
    .i_riscv_wbstage_clk (i_riscv_datapath_clk),
    .i_rst               (i_rst),
    .i_stall             (i_stall),
    .i_alu_result        (alu_result_e),
    .i_pc4               (pc4_e),
    .i_imm               (imm_e),
    .i_rd                (rd_e),
    .i_regw              (regw_e),
    .i_resultsrc         (resultsrc_e),
    .i_valid             (valid_e),
    .o_wb                (o_wb)
  );

endmodule

// ==== source/riscv_wbstage.sv ====
module riscv_wbstage (
  input  logic                 i_riscv_wbstage_clk,
  input  logic                 i_rst,
  input  logic                 i_stall,
  input  riscv_pkg::xlen_t     i_alu_result,
  input  riscv_pkg::xlen_t     i_pc4,
  input  riscv_pkg::xlen_t     i_imm,
  input  riscv_pkg::reg_addr_t i_rd,
  input  logic                 i_regw,
  input  riscv_pkg::res_src_t  i_resultsrc,
  input  logic                 i_valid,
  output riscv_pkg::riscv_wb_t o_wb
);

  logic                 wen_q;
  riscv_pkg::xlen_t     alu_q;
  riscv_pkg::xlen_t     pc4_q;
  riscv_pkg::xlen_t     imm_q;
  riscv_pkg::reg_addr_t rd_q;
  riscv_pkg::res_src_t  src_q;

  always_ff @(posedge i_riscv_wbstage_clk) begin
    if (i_rst) begin
      wen_q <= 1'b0;
    end else if (!i_stall) begin
      wen_q <= i_valid && i_regw;  // live instruction that writes rd
    end
  end

  always_ff @(posedge i_riscv_wbstage_clk) begin
    if (!i_stall) begin
      alu_q <= i_alu_result;
      pc4_q <= i_pc4;
      imm_q <= i_imm;
      rd_q  <= i_rd;
      src_q <= i_resultsrc;
    end
  end

  always_comb begin
    o_wb.valid = wen_q && (rd_q != '0) && !i_stall;  // held entry shows once
    o_wb.rd    = rd_q;
    case (src_q)
      riscv_pkg::RES_PC4: o_wb.data = pc4_q;
      riscv_pkg::RES_IMM: o_wb.data = imm_q;
      default:            o_wb.data = alu_q;
    endcase
  end

endmodule

// ==== source/riscv_estage.sv ====
module riscv_estage (
  input  logic                   i_riscv_estage_clk,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  riscv_pkg::xlen_t       i_pc,
  input  riscv_pkg::xlen_t       i_pc4,
  input  riscv_pkg::xlen_t       i_rs1data,
  input  riscv_pkg::xlen_t       i_rs2data,
  input  riscv_pkg::xlen_t       i_imm,
  input  riscv_pkg::reg_addr_t   i_rd,
  input  riscv_pkg::riscv_ctrl_t i_ctrl,
  input  logic                   i_valid,
  output logic                   o_redirect,
  output riscv_pkg::xlen_t       o_alu_result,
  output riscv_pkg::xlen_t       o_pc4,
  output riscv_pkg::xlen_t       o_imm,
  output riscv_pkg::reg_addr_t   o_rd,
  output logic                   o_regw,
  output riscv_pkg::res_src_t    o_resultsrc,
  output logic                   o_valid
);

  logic                   valid_q;
  riscv_pkg::riscv_ctrl_t ctrl_q;
  riscv_pkg::xlen_t       pc_q;
  riscv_pkg::xlen_t       pc4_q;
  riscv_pkg::xlen_t       rs1_q;
  riscv_pkg::xlen_t       rs2_q;
  riscv_pkg::xlen_t       imm_q;
  riscv_pkg::reg_addr_t   rd_q;
  riscv_pkg::xlen_t       opa;
  riscv_pkg::xlen_t       opb;
  logic                   taken;
  logic                   redirect;

  ////////////////////
  // decode/execute register

  always_ff @(posedge i_riscv_estage_clk) begin
    if (i_rst || redirect) begin
      valid_q <= 1'b0;  // drop the instruction behind a taken branch
      ctrl_q  <= '0;
    end else if (!i_stall) begin
      valid_q <= i_valid;
      ctrl_q  <= i_ctrl;
    end
  end

  always_ff @(posedge i_riscv_estage_clk) begin
    if (!i_stall) begin
      pc_q  <= i_pc;
      pc4_q <= i_pc4;
      rs1_q <= i_rs1data;
      rs2_q <= i_rs2data;
      imm_q <= i_imm;
      rd_q  <= i_rd;
    end
  end

  ////////////////////
  // alu and branch unit side by side

  assign opa = ctrl_q.asel ? pc_q : rs1_q;
  assign opb = ctrl_q.bsel ? imm_q : rs2_q;

  riscv_alu u_riscv_alu (
    .i_a      (opa),
    .i_b      (opb),
    .i_op     (ctrl_q.aluctrl),
    .o_result (o_alu_result)  // also the redirect target
  );

  riscv_bcu u_riscv_bcu (
    .i_a     (rs1_q),
    .i_b     (rs2_q),
    .i_cond  (ctrl_q.bcond),
    .o_taken (taken)
  );

  assign redirect    = valid_q && !i_stall && (ctrl_q.jump || taken);
  assign o_redirect  = redirect;
  assign o_pc4       = pc4_q;
  assign o_imm       = imm_q;
  assign o_rd        = rd_q;
  assign o_regw      = ctrl_q.regw;
  assign o_resultsrc = ctrl_q.resultsrc;
  assign o_valid     = valid_q;

endmodule

// ==== source/riscv_bcu.sv ====
module riscv_bcu (
  input  riscv_pkg::xlen_t  i_a,
  input  riscv_pkg::xlen_t  i_b,
  input  riscv_pkg::bcond_t i_cond,
  output logic              o_taken
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = i_a == i_b;
  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;

  always_comb begin
    case (i_cond)
      riscv_pkg::BR_EQ:  o_taken = eq;
      riscv_pkg::BR_NE:  o_taken = !eq;
      riscv_pkg::BR_LT:  o_taken = lt_s;
      riscv_pkg::BR_GE:  o_taken = !lt_s;
      riscv_pkg::BR_LTU: o_taken = lt_u;
      riscv_pkg::BR_GEU: o_taken = !lt_u;
      default:           o_taken = 1'b0;  // BR_NONE and spare code
    endcase
  end

endmodule

// ==== source/riscv_alu.sv ====
module riscv_alu (
  input  riscv_pkg::xlen_t   i_a,
  input  riscv_pkg::xlen_t   i_b,
  input  riscv_pkg::alu_op_t i_op,
  output riscv_pkg::xlen_t   o_result
);

  logic [5:0] shamt;  // rv64 shifts use six bits
  logic       lt_s;
  logic       lt_u;

  assign shamt = i_b[5:0];
  assign lt_s  = $signed(i_a) < $signed(i_b);
  assign lt_u  = i_a < i_b;

  always_comb begin
    case (i_op)
      riscv_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      riscv_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      riscv_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      riscv_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      riscv_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      riscv_pkg::ALU_SLT: begin
        o_result = riscv_pkg::xlen_t'(lt_s);
      end
      riscv_pkg::ALU_SLTU: begin
        o_result = riscv_pkg::xlen_t'(lt_u);
      end
      riscv_pkg::ALU_SLL: begin
        o_result = i_a << shamt;
      end
      riscv_pkg::ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      riscv_pkg::ALU_SRA: begin
        o_result = riscv_pkg::xlen_t'($signed(i_a) >>> shamt);  // sign fill
      end
      default: begin
        o_result = '0;  // unused codes
      end
    endcase
  end

endmodule

// ==== source/riscv_dstage.sv ====
module riscv_dstage (
  input  logic                   i_riscv_dstage_clk,
  input  logic                   i_rst,
  input  logic                   i_stall,
  input  logic                   i_flush,
  input  riscv_pkg::xlen_t       i_pc,
  input  riscv_pkg::inst_t       i_inst,
  input  riscv_pkg::riscv_ctrl_t i_ctrl,
  input  riscv_pkg::riscv_wb_t   i_wb,
  output riscv_pkg::xlen_t       o_pc,
  output riscv_pkg::xlen_t       o_pc4,
  output riscv_pkg::xlen_t       o_rs1data,
  output riscv_pkg::xlen_t       o_rs2data,
  output riscv_pkg::xlen_t       o_imm,
  output riscv_pkg::reg_addr_t   o_rd,
  output riscv_pkg::riscv_ctrl_t o_ctrl,
  output logic                   o_valid
);

  logic                   valid_q;
  riscv_pkg::riscv_ctrl_t ctrl_q;
  riscv_pkg::xlen_t       pc_q;
  riscv_pkg::inst_t       inst_q;
  riscv_pkg::reg_addr_t   rs1;
  riscv_pkg::reg_addr_t   rs2;

  ////////////////////
  // fetch/decode register

  always_ff @(posedge i_riscv_dstage_clk) begin
    if (i_rst || i_flush) begin
      valid_q <= 1'b0;  // bubble
      ctrl_q  <= '0;
    end else if (!i_stall) begin
      valid_q <= 1'b1;
      ctrl_q  <= i_ctrl;
    end
  end

  always_ff @(posedge i_riscv_dstage_clk) begin
    if (!i_stall) begin
      pc_q   <= i_pc;
      inst_q <= i_inst;
    end
  end

  ////////////////////
  // fields and immediate

  assign rs1  = inst_q[19:15];
  assign rs2  = inst_q[24:20];
  assign o_rd = inst_q[11:7];

  always_comb begin
    case (ctrl_q.immsrc)
      riscv_pkg::IMM_B: o_imm = {{51{inst_q[31]}}, inst_q[31], inst_q[7],
                                 inst_q[30:25], inst_q[11:8], 1'b0};
      riscv_pkg::IMM_U: o_imm = {{32{inst_q[31]}}, inst_q[31:12], 12'b0};
      riscv_pkg::IMM_J: o_imm = {{43{inst_q[31]}}, inst_q[31], inst_q[19:12],
                                 inst_q[20], inst_q[30:21], 1'b0};
      default:          o_imm = {{52{inst_q[31]}}, inst_q[31:20]};  // I-type
    endcase
  end

  riscv_regfile u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_dstage_clk),
    .i_rst               (i_rst),
    .i_rs1               (rs1),
    .i_rs2               (rs2),
    .i_wb                (i_wb),
    .o_rs1data           (o_rs1data),
    .o_rs2data           (o_rs2data)
  );

  assign o_pc    = pc_q;
  assign o_pc4   = pc_q + riscv_pkg::xlen_t'(4);
  assign o_ctrl  = ctrl_q;
  assign o_valid = valid_q;

endmodule

// ==== source/riscv_regfile.sv ====
module riscv_regfile (
  input  logic                 i_riscv_regfile_clk,
  input  logic                 i_rst,
  input  riscv_pkg::reg_addr_t i_rs1,
  input  riscv_pkg::reg_addr_t i_rs2,
  input  riscv_pkg::riscv_wb_t i_wb,
  output riscv_pkg::xlen_t     o_rs1data,
  output riscv_pkg::xlen_t     o_rs2data
);

  riscv_pkg::xlen_t regs [1:riscv_pkg::NUM_REGS-1];  // x0 is not stored

  // x0 reads zero, a same-cycle write is passed through
  function automatic riscv_pkg::xlen_t read_port(input riscv_pkg::reg_addr_t addr);
    riscv_pkg::xlen_t value;
    if (addr == '0) begin
      value = '0;
    end else if (i_wb.valid && (i_wb.rd == addr)) begin
      value = i_wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge i_riscv_regfile_clk) begin
    if (i_rst) begin
      for (int i = 1; i < riscv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid) begin
      regs[i_wb.rd] <= i_wb.data;  // writeback never targets x0
    end
  end

  assign o_rs1data = read_port(i_rs1);
  assign o_rs2data = read_port(i_rs2);

endmodule

// ==== source/riscv_fstage.sv ====
module riscv_fstage (
  input  logic             i_riscv_fstage_clk,
  input  logic             i_rst,
  input  logic             i_stall,
  input  logic             i_redirect,
  input  riscv_pkg::xlen_t i_target,
  output riscv_pkg::xlen_t o_pc
);

  riscv_pkg::xlen_t pc_q;
  riscv_pkg::xlen_t pc_next;

  always_comb begin
    if (i_redirect) begin
      pc_next = {i_target[riscv_pkg::XLEN-1:1], 1'b0};  // jalr clears bit 0
    end else begin
      pc_next = pc_q + riscv_pkg::xlen_t'(4);
    end
  end

  always_ff @(posedge i_riscv_fstage_clk) begin
    if (i_rst) begin
      pc_q <= riscv_pkg::RESET_PC;
    end else if (!i_stall) begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;  // straight to instruction memory

endmodule

// ==== source/riscv_pkg.sv ====
package riscv_pkg;

  ////////////////////
  // widths and basic types

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]   xlen_t;      // data word or address
  typedef logic [31:0]       inst_t;      // one instruction word
  typedef logic [REG_AW-1:0] reg_addr_t;  // register index
  typedef logic [3:0]        alu_op_t;
  typedef logic [2:0]        bcond_t;
  typedef logic [1:0]        imm_src_t;
  typedef logic [1:0]        res_src_t;

  localparam xlen_t RESET_PC = '0;  // first fetch after reset

  ////////////////////
  // alu operations

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLTU = 4'd6;
  localparam alu_op_t ALU_SLL  = 4'd7;
  localparam alu_op_t ALU_SRL  = 4'd8;
  localparam alu_op_t ALU_SRA  = 4'd9;

  // branch conditions
  localparam bcond_t BR_NONE = 3'd0;  // never taken
  localparam bcond_t BR_EQ   = 3'd1;
  localparam bcond_t BR_NE   = 3'd2;
  localparam bcond_t BR_LT   = 3'd3;
  localparam bcond_t BR_GE   = 3'd4;
  localparam bcond_t BR_LTU  = 3'd5;
  localparam bcond_t BR_GEU  = 3'd6;

  // immediate formats, all sign extended
  localparam imm_src_t IMM_I = 2'd0;
  localparam imm_src_t IMM_B = 2'd1;
  localparam imm_src_t IMM_U = 2'd2;
  localparam imm_src_t IMM_J = 2'd3;

  // write-back sources
  localparam res_src_t RES_ALU = 2'd0;
  localparam res_src_t RES_PC4 = 2'd1;  // link address of jal/jalr
  localparam res_src_t RES_IMM = 2'd2;  // lui

  ////////////////////
  // bundles

  typedef struct packed {
    logic     regw;       // writes rd
    logic     jump;       // jal or jalr
    logic     asel;       // operand a is pc
    logic     bsel;       // operand b is immediate
    imm_src_t immsrc;
    alu_op_t  aluctrl;
    bcond_t   bcond;
    res_src_t resultsrc;
  } riscv_ctrl_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } riscv_wb_t;

endpackage
